// ==== wiscIsaPkg.sv ====
//////////////////////////////////////////////////
// WISC-SP22 instruction set definitions
// Word types, field positions and major opcodes,
// imported by the decode and execute stages
//////////////////////////////////////////////////
`default_nettype none

package wiscIsaPkg;

   // Data word and raw instruction
   typedef logic [15:0] wordT;
   typedef logic [15:0] instrT;

   // Instruction fields
   typedef logic [4:0] opcodeT;
   typedef logic [2:0] regSelT;
   typedef logic [1:0] functT;

   // Low bit of each field within the instruction
   localparam int opcodeLsb = 11;
   localparam int rsLsb     = 8;
   localparam int rtLsb     = 5;
   // I-format 1 destination shares its slot with Rt
   localparam int rdILsb    = 5;
   localparam int rdRLsb    = 2;

   // Immediate field widths
   localparam int imm5W = 5;
   localparam int imm8W = 8;

   ////////////////////////////////////////////////
   // Major opcodes kept by this core
   ////////////////////////////////////////////////
   localparam opcodeT opNop    = 5'b00001;
   localparam opcodeT opAddi   = 5'b01000;
   localparam opcodeT opSubi   = 5'b01001;
   localparam opcodeT opXori   = 5'b01010;
   localparam opcodeT opAndni  = 5'b01011;
   localparam opcodeT opRoli   = 5'b10100;
   localparam opcodeT opSlli   = 5'b10101;
   localparam opcodeT opRori   = 5'b10110;
   localparam opcodeT opSrli   = 5'b10111;
   localparam opcodeT opSlbi   = 5'b10010;
   localparam opcodeT opLbi    = 5'b11000;
   localparam opcodeT opBtr    = 5'b11001;
   // Register shifts, funct picks the kind
   localparam opcodeT opShiftR = 5'b11010;
   // Register ALU ops, funct picks the kind
   localparam opcodeT opAluR   = 5'b11011;
   localparam opcodeT opSeq    = 5'b11100;
   localparam opcodeT opSlt    = 5'b11101;
   localparam opcodeT opSle    = 5'b11110;
   localparam opcodeT opSco    = 5'b11111;

endpackage

`default_nettype wire

// ==== wiscCtrlPkg.sv ====
//////////////////////////////////////////////////
// Internal control word of the WISC core
// Shared by decode (producer) and aluExecute
//////////////////////////////////////////////////
`default_nettype none

package wiscCtrlPkg;

   // ALU operation, low two bits follow funct / opcode
   typedef logic [2:0] aluOpT;
   localparam aluOpT aluAdd  = 3'd0;
   // Second operand minus first
   localparam aluOpT aluSub  = 3'd1;
   localparam aluOpT aluXor  = 3'd2;
   localparam aluOpT aluAndn = 3'd3;
   localparam aluOpT aluRol  = 3'd4;
   localparam aluOpT aluSll  = 3'd5;
   localparam aluOpT aluRor  = 3'd6;
   localparam aluOpT aluSrl  = 3'd7;

   // Second operand select
   typedef logic [1:0] bSrcT;
   localparam bSrcT bSrcRt   = 2'd0;
   localparam bSrcT bSrcImm  = 2'd1;
   localparam bSrcT bSrcZero = 2'd2;

   // Result select, five sources
   typedef logic [2:0] resSrcT;
   localparam resSrcT resAlu  = 3'd0;
   localparam resSrcT resImm  = 3'd1;
   localparam resSrcT resSlbi = 3'd2;
   localparam resSrcT resBtr  = 3'd3;
   localparam resSrcT resSet  = 3'd4;

   // Compare kind, matches opcode[1:0] of the set group
   typedef logic [1:0] cmpT;
   localparam cmpT cmpEq = 2'd0;
   localparam cmpT cmpLt = 2'd1;
   localparam cmpT cmpLe = 2'd2;
   localparam cmpT cmpCo = 2'd3;

endpackage

`default_nettype wire

// ==== regFile.sv ====
//////////////////////////////////////////////////
// Register file, numRegs x 16 bits
// Two combinational read ports with write-through,
// one synchronous write port
//////////////////////////////////////////////////
`default_nettype none

module regFile #(
   parameter int numRegs = 8
) (
   input  logic               clk,
   input  logic               reset,
   input  wiscIsaPkg::regSelT rdSelA,
   input  wiscIsaPkg::regSelT rdSelB,
   output wiscIsaPkg::wordT   rdDataA,
   output wiscIsaPkg::wordT   rdDataB,
   input  logic               wrEn,
   input  wiscIsaPkg::regSelT wrReg,
   input  wiscIsaPkg::wordT   wrData
);
   import wiscIsaPkg::*;

   wordT regs [numRegs];

   // Registers above numRegs read as zero and ignore writes
   function automatic wordT readPort(input regSelT sel);
      wordT value;
      value = '0;
      if (int'(sel) < numRegs) begin
         // Forward the write in flight to a dependent read
         if (wrEn && (wrReg == sel)) begin
            value = wrData;
         end else begin
            value = regs[sel];
         end
      end
      return value;
   endfunction

   // Write commits at the edge that ends the write-back cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && (int'(wrReg) < numRegs)) begin
         regs[wrReg] <= wrData;
      end
   end

   always_comb begin
      rdDataA = readPort(rdSelA);
      rdDataB = readPort(rdSelB);
   end

endmodule

`default_nettype wire

// ==== decode.sv ====
//////////////////////////////////////////////////
// Decode stage
// Splits the instruction, builds the control word,
// extends the immediate and reads Rs and Rt
//////////////////////////////////////////////////
`default_nettype none

module decode #(
   parameter int numRegs = 8
) (
   input  logic                clk,
   input  logic                reset,
   input  wiscIsaPkg::instrT   instr,
   input  logic                instrValid,
   input  logic                wrEn,
   input  wiscIsaPkg::regSelT  wrReg,
   input  wiscIsaPkg::wordT    wrData,
   output logic                exValid,
   output logic                exIllegal,
   output wiscCtrlPkg::aluOpT  exOp,
   output wiscCtrlPkg::bSrcT   exBSrc,
   output wiscCtrlPkg::resSrcT exResSrc,
   output wiscCtrlPkg::cmpT    exCmp,
   output wiscIsaPkg::regSelT  exRd,
   output wiscIsaPkg::wordT    exA,
   output wiscIsaPkg::wordT    exB,
   output wiscIsaPkg::wordT    exImm
);
   import wiscIsaPkg::*;
   import wiscCtrlPkg::*;

   localparam int wordW = $bits(wordT);
   localparam int selW  = $bits(regSelT);

   opcodeT opcode;
   functT  funct;
   regSelT rsSel, rtSel, rdR, rdI;
   wordT   imm5Sext, imm5Zext, imm8Sext, imm8Zext;
   // NOP is legal but writes nothing
   logic   isLegal, regWrite;

   ////////////////////////////////////////////////
   // Fields and immediates
   ////////////////////////////////////////////////
   assign opcode = instr[opcodeLsb +: $bits(opcodeT)];
   assign funct  = instr[$bits(functT)-1:0];
   assign rsSel  = instr[rsLsb +: selW];
   assign rtSel  = instr[rtLsb +: selW];
   assign rdR    = instr[rdRLsb +: selW];
   assign rdI    = instr[rdILsb +: selW];

   assign imm5Sext = {{(wordW-imm5W){instr[imm5W-1]}}, instr[imm5W-1:0]};
   assign imm5Zext = {{(wordW-imm5W){1'b0}}, instr[imm5W-1:0]};
   assign imm8Sext = {{(wordW-imm8W){instr[imm8W-1]}}, instr[imm8W-1:0]};
   assign imm8Zext = {{(wordW-imm8W){1'b0}}, instr[imm8W-1:0]};

   ////////////////////////////////////////////////
   // Control word
   ////////////////////////////////////////////////
   always_comb begin
      isLegal  = 1'b1;
      regWrite = 1'b1;
      exOp     = aluAdd;
      exBSrc   = bSrcZero;
      exResSrc = resAlu;
      exCmp    = cmpEq;
      exRd     = rdR;
      exImm    = imm5Sext;
      case (opcode)
         opNop: regWrite = 1'b0;
         // Immediate arithmetic, XORI and ANDNI zero-extend
         opAddi, opSubi, opXori, opAndni: begin
            exOp   = {1'b0, opcode[1:0]};
            exBSrc = bSrcImm;
            exRd   = rdI;
            if ((opcode == opXori) || (opcode == opAndni)) begin
               exImm = imm5Zext;
            end
         end
         // Immediate shifts use the low four bits only
         opRoli, opSlli, opRori, opSrli: begin
            exOp   = {1'b1, opcode[1:0]};
            exBSrc = bSrcImm;
            exRd   = rdI;
         end
         // Load immediates write back into Rs
         opLbi: begin
            exResSrc = resImm;
            exRd     = rsSel;
            exImm    = imm8Sext;
         end
         opSlbi: begin
            exResSrc = resSlbi;
            exRd     = rsSel;
            exImm    = imm8Zext;
         end
         opBtr: exResSrc = resBtr;
         opAluR: begin
            exOp   = {1'b0, funct};
            exBSrc = bSrcRt;
         end
         opShiftR: begin
            exOp   = {1'b1, funct};
            exBSrc = bSrcRt;
         end
         opSeq, opSlt, opSle, opSco: begin
            exBSrc   = bSrcRt;
            exResSrc = resSet;
            case (opcode)
               opSeq:   exCmp = cmpEq;
               opSlt:   exCmp = cmpLt;
               opSle:   exCmp = cmpLe;
               default: exCmp = cmpCo;
            endcase
         end
         // Branches, jumps, memory, HALT, SIIC and unassigned
         default: begin
            isLegal  = 1'b0;
            regWrite = 1'b0;
         end
      endcase
   end

   assign exValid   = instrValid & regWrite;
   assign exIllegal = instrValid & ~isLegal;

   // Port A reads Rs, port B reads Rt
   regFile #(
      .numRegs(numRegs)
   ) regFileInst (
      .clk    (clk),
      .reset  (reset),
      .rdSelA (rsSel),
      .rdSelB (rtSel),
      .rdDataA(exA),
      .rdDataB(exB),
      .wrEn   (wrEn),
      .wrReg  (wrReg),
      .wrData (wrData)
   );

endmodule

`default_nettype wire

// ==== aluExecute.sv ====
//////////////////////////////////////////////////
// Execute stage
// Registers the decoded instruction, computes the
// result and drives the register file write
//////////////////////////////////////////////////
`default_nettype none

module aluExecute (
   input  logic                clk,
   input  logic                reset,
   input  logic                exValid,
   input  logic                exIllegal,
   input  wiscCtrlPkg::aluOpT  exOp,
   input  wiscCtrlPkg::bSrcT   exBSrc,
   input  wiscCtrlPkg::resSrcT exResSrc,
   input  wiscCtrlPkg::cmpT    exCmp,
   input  wiscIsaPkg::regSelT  exRd,
   input  wiscIsaPkg::wordT    exA,
   input  wiscIsaPkg::wordT    exB,
   input  wiscIsaPkg::wordT    exImm,
   output logic                wrEn,
   output wiscIsaPkg::regSelT  wrReg,
   output wiscIsaPkg::wordT    wrData,
   output logic                illegal
);
   import wiscIsaPkg::*;
   import wiscCtrlPkg::*;

   localparam int wordW = $bits(wordT);

   logic   validQ, illegalQ;
   aluOpT  opQ;
   bSrcT   bSrcQ;
   resSrcT resSrcQ;
   cmpT    cmpQ;
   regSelT rdQ;
   wordT   aQ, bQ, immQ;

   wordT         opB, aluRes, btrVal;
   logic [3:0]   shamt;
   logic [wordW:0]     sumWide;
   logic [2*wordW-1:0] rolWide, rorWide;
   logic         setFlag;

   ////////////////////////////////////////////////
   // Stage registers
   ////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         validQ   <= 1'b0;
         illegalQ <= 1'b0;
      end else begin
         validQ   <= exValid;
         illegalQ <= exIllegal;
      end
   end

   // Payload, only meaningful while validQ is high
   always_ff @(posedge clk) begin
      opQ     <= exOp;
      bSrcQ   <= exBSrc;
      resSrcQ <= exResSrc;
      cmpQ    <= exCmp;
      rdQ     <= exRd;
      aQ      <= exA;
      bQ      <= exB;
      immQ    <= exImm;
   end

   ////////////////////////////////////////////////
   // ALU
   ////////////////////////////////////////////////
   always_comb begin
      case (bSrcQ)
         bSrcRt:  opB = bQ;
         bSrcImm: opB = immQ;
         default: opB = '0;
      endcase
   end

   assign shamt   = opB[3:0];
   // Carry out of this sum feeds SCO
   assign sumWide = {1'b0, aQ} + {1'b0, opB};
   // Rotates from a doubled copy of Rs
   assign rolWide = {aQ, aQ} << shamt;
   assign rorWide = {aQ, aQ} >> shamt;

   always_comb begin
      case (opQ)
         aluAdd:  aluRes = sumWide[wordW-1:0];
         aluSub:  aluRes = opB - aQ;
         aluXor:  aluRes = aQ ^ opB;
         aluAndn: aluRes = aQ & ~opB;
         aluRol:  aluRes = rolWide[2*wordW-1:wordW];
         aluSll:  aluRes = aQ << shamt;
         aluRor:  aluRes = rorWide[wordW-1:0];
         default: aluRes = aQ >> shamt;
      endcase
   end

   // Signed compares for SLT and SLE
   always_comb begin
      case (cmpQ)
         cmpEq:   setFlag = (aQ == opB);
         cmpLt:   setFlag = ($signed(aQ) < $signed(opB));
         cmpLe:   setFlag = ($signed(aQ) <= $signed(opB));
         default: setFlag = sumWide[wordW];
      endcase
   end

   // BTR mirrors Rs bit by bit
   always_comb begin
      for (int i = 0; i < wordW; i++) begin
         btrVal[i] = aQ[wordW-1-i];
      end
   end

   ////////////////////////////////////////////////
   // Result select and write-back
   ////////////////////////////////////////////////
   always_comb begin
      case (resSrcQ)
         resImm:  wrData = immQ;
         resSlbi: wrData = (aQ << 8) | immQ;
         resBtr:  wrData = btrVal;
         resSet:  wrData = {{(wordW-1){1'b0}}, setFlag};
         default: wrData = aluRes;
      endcase
   end

   assign wrEn    = validQ;
   assign wrReg   = rdQ;
   assign illegal = illegalQ;

endmodule

`default_nettype wire

// ==== wiscCore.sv ====
//////////////////////////////////////////////////
// WISC core top level
// Decode feeds the execute stage, which writes
// back one cycle after an instruction is taken
//////////////////////////////////////////////////
`default_nettype none

module wiscCore #(
   parameter int numRegs = 8
) (
   input  logic               clk,
   input  logic               reset,
   input  wiscIsaPkg::instrT  instr,
   input  logic               instrValid,
   output logic               wbValid,
   output wiscIsaPkg::regSelT wbReg,
   output wiscIsaPkg::wordT   wbData,
   output logic               illegal
);
   import wiscIsaPkg::*;
   import wiscCtrlPkg::*;

   // Decode to execute
   logic   exValid, exIllegal;
   aluOpT  exOp;
   bSrcT   exBSrc;
   resSrcT exResSrc;
   cmpT    exCmp;
   regSelT exRd;
   wordT   exA, exB, exImm;

   // Write-back loop into the register file
   logic   wrEn;
   regSelT wrReg;
   wordT   wrData;

   decode #(
      .numRegs(numRegs)
   ) decodeInst (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .instrValid(instrValid),
      .wrEn      (wrEn),
      .wrReg     (wrReg),
      .wrData    (wrData),
      .exValid   (exValid),
      .exIllegal (exIllegal),
      .exOp      (exOp),
      .exBSrc    (exBSrc),
      .exResSrc  (exResSrc),
      .exCmp     (exCmp),
      .exRd      (exRd),
      .exA       (exA),
      .exB       (exB),
      .exImm     (exImm)
   );

   aluExecute aluExecuteInst (
      .clk      (clk),
      .reset    (reset),
      .exValid  (exValid),
      .exIllegal(exIllegal),
      .exOp     (exOp),
      .exBSrc   (exBSrc),
      .exResSrc (exResSrc),
      .exCmp    (exCmp),
      .exRd     (exRd),
      .exA      (exA),
      .exB      (exB),
      .exImm    (exImm),
      .wrEn     (wrEn),
      .wrReg    (wrReg),
      .wrData   (wrData),
      .illegal  (illegal)
   );

   // Observation ports show the write in progress
   assign wbValid = wrEn;
   assign wbReg   = wrReg;
   assign wbData  = wrData;

endmodule

`default_nettype wire

// ==== wiscCore_props.sv ====
//////////////////////////////////////////////////
// Timing properties of the WISC core
// Bound into every wiscCore instance
//////////////////////////////////////////////////
`default_nettype none

module wiscCoreProps (
   input logic               clk,
   input logic               reset,
   input wiscIsaPkg::instrT  instr,
   input logic               instrValid,
   input logic               wbValid,
   input wiscIsaPkg::regSelT wbReg,
   input logic               illegal
);
   import wiscIsaPkg::*;

   // Failure count, read by the testbench at the end
   int unsigned propErrors = 0;

   opcodeT opcode;
   logic   writesReg, unsupported;
   regSelT destReg;

   ////////////////////////////////////////////////
   // Instruction classes seen at the port
   ////////////////////////////////////////////////
   assign opcode = instr[15:11];

   // NOP writes nothing and opcodes outside the kept set are illegal
   always_comb begin
      writesReg   = 1'b0;
      unsupported = 1'b0;
      case (opcode)
         opNop: writesReg = 1'b0;
         opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli,
         opLbi, opSlbi, opBtr, opAluR, opShiftR, opSeq, opSlt, opSle, opSco:
            writesReg = 1'b1;
         default: unsupported = 1'b1;
      endcase
   end

   // Destination slot depends on the format
   always_comb begin
      case (opcode)
         opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli:
            destReg = instr[7:5];
         opLbi, opSlbi: destReg = instr[10:8];
         default: destReg = instr[4:2];
      endcase
   end

   // Outputs quiet in the cycle after a reset cycle
   resetQuiet: assert property (@(posedge clk) reset |=> (!wbValid && !illegal))
      else begin
         $error("write-back or illegal active right after reset");
         propErrors++;
      end

   // No instruction taken means nothing shows next cycle
   idleQuiet: assert property (@(posedge clk) disable iff (reset)
      !instrValid |=> (!wbValid && !illegal))
      else begin
         $error("output activity without an accepted instruction");
         propErrors++;
      end

   // Legal write lands exactly one cycle later on its destination
   writeLatency: assert property (@(posedge clk) disable iff (reset)
      (instrValid && writesReg) |=> (wbValid && !illegal && (wbReg == $past(destReg))))
      else begin
         $error("write-back missing, flagged illegal or on the wrong register");
         propErrors++;
      end

   // NOP is accepted but leaves both outputs low
   nopQuiet: assert property (@(posedge clk) disable iff (reset)
      (instrValid && (opcode == opNop)) |=> (!wbValid && !illegal))
      else begin
         $error("NOP wrote a register or was flagged illegal");
         propErrors++;
      end

   // Illegal opcode flags one cycle later and never writes
   illegalLatency: assert property (@(posedge clk) disable iff (reset)
      (instrValid && unsupported) |=> (illegal && !wbValid))
      else begin
         $error("illegal opcode not flagged or it wrote a register");
         propErrors++;
      end

endmodule

bind wiscCore wiscCoreProps propsInst (
   .clk       (clk),
   .reset     (reset),
   .instr     (instr),
   .instrValid(instrValid),
   .wbValid   (wbValid),
   .wbReg     (wbReg),
   .illegal   (illegal)
);

`default_nettype wire

// ==== wiscCoreTb.sv ====
//////////////////////////////////////////////////
// Testbench for the WISC decode and execute core
// Directed and random instructions against a
// shadow register model, timing via bound props
//////////////////////////////////////////////////
`default_nettype none

module wiscCoreTb;
   import wiscIsaPkg::*;

   localparam int period      = 40;
   localparam int maxDirected = 40;
   localparam int numRandom   = 200;
   localparam int watchdogTime = (maxDirected + numRandom + 50) * period;

   logic   clk;
   logic   reset;
   instrT  instr;
   logic   instrValid;
   logic   wbValid;
   regSelT wbReg;
   wordT   wbData;
   logic   illegal;

   // Shadow register file and expected results in issue order
   wordT   shadow [8];
   regSelT lastDest;
   int     expDue[$];
   int     expKind[$];
   regSelT expReg[$];
   wordT   expData[$];
   int     negCount = 0;
   int     dataErrors = 0;
   int     kindNow;
   int unsigned pick;
   regSelT rs, rt, rd;
   functT  funct;

   wiscCore #(
      .numRegs(8)
   ) UUT (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .instrValid(instrValid),
      .wbValid   (wbValid),
      .wbReg     (wbReg),
      .wbData    (wbData),
      .illegal   (illegal)
   );

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   initial begin
      #(watchdogTime);
      $display("Watchdog expired, the run did not finish in %0d time units", watchdogTime);
      $display("TESTBENCH FAILED");
      $finish;
   end

   ////////////////////////////////////////////////
   // Encoders and reference model
   ////////////////////////////////////////////////
   function automatic instrT makeRType(input opcodeT op, input regSelT s, input regSelT t,
                                       input regSelT d, input functT f);
      return {op, s, t, d, f};
   endfunction

   function automatic instrT makeIType(input opcodeT op, input regSelT s, input regSelT d,
                                       input logic [4:0] imm);
      return {op, s, d, imm};
   endfunction

   function automatic instrT makeLoadImm(input opcodeT op, input regSelT s,
                                         input logic [7:0] imm);
      return {op, s, imm};
   endfunction

   function automatic opcodeT pickImmOp(input logic [2:0] k);
      opcodeT op;
      case (k)
         3'd0: op = opAddi;
         3'd1: op = opSubi;
         3'd2: op = opXori;
         3'd3: op = opAndni;
         3'd4: op = opRoli;
         3'd5: op = opSlli;
         3'd6: op = opRori;
         default: op = opSrli;
      endcase
      return op;
   endfunction

   function automatic opcodeT pickSetOp(input functT k);
      opcodeT op;
      case (k)
         2'd0: op = opSeq;
         2'd1: op = opSlt;
         2'd2: op = opSle;
         default: op = opSco;
      endcase
      return op;
   endfunction

   // A shift of 16 bits yields zero, so n of 0 keeps x
   function automatic wordT rotateLeft(input wordT x, input int n);
      return (x << n) | (x >> (16 - n));
   endfunction

   function automatic wordT rotateRight(input wordT x, input int n);
      return (x >> n) | (x << (16 - n));
   endfunction

   function automatic wordT reverseBits(input wordT x);
      wordT y;
      for (int i = 0; i < 16; i++) begin
         y[i] = x[15 - i];
      end
      return y;
   endfunction

   // Result due two negedges after the issuing edge
   task automatic predict(input instrT ins);
      opcodeT op;
      wordT   a, b, imm5s, imm5z, imm8s, imm8z, result;
      logic [16:0] wide;
      logic   writes, bad;
      regSelT dest;
      op     = ins[15:11];
      a      = shadow[ins[10:8]];
      b      = shadow[ins[7:5]];
      imm5s  = {{11{ins[4]}}, ins[4:0]};
      imm5z  = {11'b0, ins[4:0]};
      imm8s  = {{8{ins[7]}}, ins[7:0]};
      imm8z  = {8'b0, ins[7:0]};
      wide   = a + b;
      writes = 1'b1;
      bad    = 1'b0;
      dest   = ins[4:2];
      result = '0;
      case (op)
         opNop: writes = 1'b0;
         opAddi: result = a + imm5s;
         opSubi: result = imm5s - a;
         opXori: result = a ^ imm5z;
         opAndni: result = a & ~imm5z;
         opRoli: result = rotateLeft(a, ins[3:0]);
         opSlli: result = a << ins[3:0];
         opRori: result = rotateRight(a, ins[3:0]);
         opSrli: result = a >> ins[3:0];
         opLbi: result = imm8s;
         opSlbi: result = (a << 8) | imm8z;
         opBtr: result = reverseBits(a);
         opAluR: begin
            case (ins[1:0])
               2'd0: result = a + b;
               2'd1: result = b - a;
               2'd2: result = a ^ b;
               default: result = a & ~b;
            endcase
         end
         opShiftR: begin
            case (ins[1:0])
               2'd0: result = rotateLeft(a, b[3:0]);
               2'd1: result = a << b[3:0];
               2'd2: result = rotateRight(a, b[3:0]);
               default: result = a >> b[3:0];
            endcase
         end
         opSeq: result = {15'b0, a == b};
         opSlt: result = {15'b0, $signed(a) < $signed(b)};
         opSle: result = {15'b0, $signed(a) <= $signed(b)};
         opSco: result = {15'b0, wide[16]};
         default: begin
            writes = 1'b0;
            bad    = 1'b1;
         end
      endcase
      // I-format 1 writes bits 7:5, load immediates write Rs
      if ((op >= opAddi && op <= opAndni) || (op >= opRoli && op <= opSrli)) begin
         dest = ins[7:5];
      end
      if (op == opLbi || op == opSlbi) begin
         dest = ins[10:8];
      end
      if (writes || bad) begin
         expDue.push_back(negCount + 2);
         expKind.push_back(bad ? 2 : 1);
         expReg.push_back(dest);
         expData.push_back(result);
      end
      if (writes) begin
         shadow[dest] = result;
         lastDest     = dest;
      end
   endtask

   ////////////////////////////////////////////////
   // Stimulus and checks
   ////////////////////////////////////////////////
   task automatic issue(input instrT ins);
      @(posedge clk);
      instr      <= ins;
      instrValid <= 1'b1;
      predict(ins);
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(posedge clk);
         instrValid <= 1'b0;
      end
   endtask

   task automatic checkValue(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
      assert (actual === expected) else begin
         dataErrors++;
         $display("Fail at time %0t: %s expected 0x%h, actual 0x%h",
                  $time, name, expected, actual);
      end
   endtask

   // Mid-cycle sampling of the write-back ports
   always @(negedge clk) begin
      negCount++;
      if (!reset) begin
         if (expDue.size() != 0 && expDue[0] == negCount) begin
            void'(expDue.pop_front());
            kindNow = expKind.pop_front();
            if (kindNow == 1) begin
               checkValue("wbValid", 16'd1, wbValid);
               checkValue("illegal", 16'd0, illegal);
               checkValue("wbReg", expReg[0], wbReg);
               checkValue("wbData", expData[0], wbData);
            end else begin
               checkValue("illegal", 16'd1, illegal);
               checkValue("wbValid", 16'd0, wbValid);
            end
            void'(expReg.pop_front());
            void'(expData.pop_front());
         end else begin
            checkValue("wbValid", 16'd0, wbValid);
            checkValue("illegal", 16'd0, illegal);
         end
      end
   end

   initial begin
      reset      = 1'b1;
      instr      = '0;
      instrValid = 1'b0;
      lastDest   = '0;
      void'($urandom(32'h0c8bf9a3));
      for (int i = 0; i < 8; i++) begin
         shadow[i] = '0;
      end
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      idle(4);

      // LBI with bit 7 set on odd registers
      for (int r = 0; r < 8; r++) begin
         issue(makeLoadImm(opLbi, regSelT'(r), (r % 2 == 1) ? 8'(8'h80 + r) : 8'(8'h10 + r)));
      end
      issue(makeLoadImm(opSlbi, 3'd0, 8'hf3));
      issue(makeLoadImm(opSlbi, 3'd1, 8'h7e));
      // Back to back on r0
      issue(makeLoadImm(opSlbi, 3'd0, 8'h81));
      // Immediates with bit 4 set for sign versus zero extension
      issue(makeIType(opAddi, 3'd1, 3'd2, 5'b11101));
      issue(makeIType(opSubi, 3'd2, 3'd3, 5'b10010));
      issue(makeIType(opXori, 3'd3, 3'd4, 5'b10110));
      issue(makeIType(opAndni, 3'd4, 3'd5, 5'b11111));
      issue(makeIType(opRoli, 3'd5, 3'd6, 5'd4));
      issue(makeIType(opSlli, 3'd6, 3'd7, 5'b10011));
      issue(makeIType(opRori, 3'd1, 3'd0, 5'd9));
      issue(makeIType(opSrli, 3'd0, 3'd1, 5'd15));
      issue(makeRType(opNop, 3'd2, 3'd2, 3'd2, 2'd0));
      idle(2);

      // Branch, jump, memory, HALT, SIIC and unassigned, then a read of Rs
      for (int k = 0; k < 7; k++) begin
         case (k)
            0: issue(makeLoadImm(5'b00000, regSelT'(k), 8'($urandom)));
            1: issue(makeLoadImm(5'b00010, regSelT'(k), 8'($urandom)));
            2: issue(makeLoadImm(5'b00100, regSelT'(k), 8'($urandom)));
            3: issue(makeLoadImm(5'b01100, regSelT'(k), 8'($urandom)));
            4: issue(makeLoadImm(5'b10000, regSelT'(k), 8'($urandom)));
            5: issue(makeLoadImm(5'b10011, regSelT'(k), 8'($urandom)));
            default: issue(makeLoadImm(5'b00110, regSelT'(k), 8'($urandom)));
         endcase
         issue(makeIType(opAddi, regSelT'(k), regSelT'(k), 5'd0));
      end

      // Random stream, half of the sources follow the last write
      for (int n = 0; n < numRandom; n++) begin
         pick  = $urandom % 10;
         rs    = ($urandom % 2 == 1) ? lastDest : regSelT'($urandom % 8);
         rt    = ($urandom % 4 == 0) ? rs : regSelT'($urandom % 8);
         rd    = regSelT'($urandom % 8);
         funct = functT'($urandom % 4);
         case (pick)
            0, 1: issue(makeRType(opAluR, rs, rt, rd, funct));
            2, 3: issue(makeRType(opShiftR, rs, rt, rd, funct));
            4: issue(makeRType(opBtr, rs, rt, rd, funct));
            5, 6: issue(makeRType(pickSetOp(funct), rs, rt, rd, 2'd0));
            7: issue(makeIType(pickImmOp(3'($urandom)), rs, rd, 5'($urandom)));
            8: issue(makeLoadImm(opLbi, rd, 8'($urandom)));
            default: issue(makeLoadImm(opSlbi, rs, 8'($urandom)));
         endcase
      end
      idle(2);
      while (expDue.size() != 0) begin
         @(negedge clk);
      end
      @(negedge clk);

      $display("Errors: %0d data, %0d timing", dataErrors, UUT.propsInst.propErrors);
      if (dataErrors == 0 && UUT.propsInst.propErrors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== wiscCore.f ====
wiscIsaPkg.sv
wiscCtrlPkg.sv
regFile.sv
decode.sv
aluExecute.sv
wiscCore.sv
wiscCore_props.sv
wiscCoreTb.sv
